// File: Makefile
# Verilator build and run for the odd pipe testbench

VERILATOR ?= verilator
TOP ?= tb_odd_pipe
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
hw/spu_pkg.sv
hw/odd_issue_if.sv
hw/stage_fwd_if.sv
hw/quad_rotator.sv
hw/register_file.sv
hw/operand_fetch.sv
hw/permute_unit.sv
hw/odd_pipe_top.sv
testbench/tb_odd_pipe.sv

// File: hw/odd_issue_if.sv
`timescale 1ns/1ns
`default_nettype none

interface odd_issue_if;
	import spu_pkg::*;

	// instruction held in the rf/fwd stage
	opcode_t op;
	instr_format_t format;
	reg_addr_t rt_addr;
	// source values after forwarding
	quad_t ra;
	quad_t rb;
	imm_t imm;
	logic reg_write;
	// squash request travelling with the instruction
	logic branch_taken;

	modport fetch (output op, format, rt_addr, ra, rb, imm, reg_write, branch_taken);
	modport exec (input op, format, rt_addr, ra, rb, imm, reg_write, branch_taken);

endinterface

`default_nettype wire

// File: hw/odd_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

module odd_pipe_top #(
	parameter int NUM_REGS = 128
) (
	input wire clk,
	input wire reset,
	input wire spu_pkg::opcode_t op,
	input wire spu_pkg::instr_format_t format,
	input wire spu_pkg::reg_addr_t rt_addr,
	input wire spu_pkg::reg_addr_t ra_addr,
	input wire spu_pkg::reg_addr_t rb_addr,
	input wire spu_pkg::imm_t imm,
	input wire reg_write,
	input wire branch_taken,
	input wire load_en,
	input wire spu_pkg::reg_addr_t load_addr,
	input wire spu_pkg::quad_t load_data,
	output spu_pkg::quad_t rt_wb,
	output spu_pkg::reg_addr_t rt_addr_wb,
	output logic reg_write_wb
);
	import spu_pkg::*;

	reg_addr_t rf_ra_addr;
	reg_addr_t rf_rb_addr;
	quad_t rf_ra_data;
	quad_t rf_rb_data;

	odd_issue_if issue_bus ();
	stage_fwd_if #(.STAGES(PERM_STAGES)) fwd_bus ();

	operand_fetch #(.NUM_REGS(NUM_REGS)) u_fetch (
		.clk(clk),
		.reset(reset),
		.op(op),
		.format(format),
		.rt_addr(rt_addr),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.imm(imm),
		.reg_write(reg_write),
		.branch_taken(branch_taken),
		.rf_ra_addr(rf_ra_addr),
		.rf_rb_addr(rf_rb_addr),
		.rf_ra_data(rf_ra_data),
		.rf_rb_data(rf_rb_data),
		.issue(issue_bus.fetch),
		.fwd(fwd_bus.sink)
	);

	permute_unit #(.PERM_STAGES(PERM_STAGES)) u_perm (
		.clk(clk),
		.reset(reset),
		.issue(issue_bus.exec),
		.fwd(fwd_bus.source),
		.rt_wb(rt_wb),
		.rt_addr_wb(rt_addr_wb),
		.reg_write_wb(reg_write_wb)
	);

	// writeback port from the last stage, load port from outside
	register_file #(.NUM_REGS(NUM_REGS)) u_rf (
		.clk(clk),
		.reset(reset),
		.ra_addr(rf_ra_addr),
		.rb_addr(rf_rb_addr),
		.ra_data(rf_ra_data),
		.rb_data(rf_rb_data),
		.wb_en(reg_write_wb),
		.wb_addr(rt_addr_wb),
		.wb_data(rt_wb),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

endmodule

`default_nettype wire

// File: hw/operand_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch #(
	parameter int NUM_REGS = 128
) (
	input wire clk,
	input wire reset,
	input wire spu_pkg::opcode_t op,
	input wire spu_pkg::instr_format_t format,
	input wire spu_pkg::reg_addr_t rt_addr,
	input wire spu_pkg::reg_addr_t ra_addr,
	input wire spu_pkg::reg_addr_t rb_addr,
	input wire spu_pkg::imm_t imm,
	input wire reg_write,
	input wire branch_taken,
	output spu_pkg::reg_addr_t rf_ra_addr,
	output spu_pkg::reg_addr_t rf_rb_addr,
	input wire spu_pkg::quad_t rf_ra_data,
	input wire spu_pkg::quad_t rf_rb_data,
	odd_issue_if.fetch issue,
	stage_fwd_if.sink fwd
);
	import spu_pkg::*;

	quad_t ra_fwd;
	quad_t rb_fwd;

	// compare after folding into the physical register range
	function automatic logic same_reg(input reg_addr_t a, input reg_addr_t b);
		return (a % NUM_REGS) == (b % NUM_REGS);
	endfunction

	assign rf_ra_addr = ra_addr;
	assign rf_rb_addr = rb_addr;

	// oldest first so a younger match overwrites
	always_comb begin
		ra_fwd = rf_ra_data;
		rb_fwd = rf_rb_data;
		for (int i = PERM_STAGES - 1; i >= 0; i--) begin
			if (fwd.wr[i] && same_reg(fwd.addr[i], ra_addr)) begin
				ra_fwd = fwd.val[i];
			end
			if (fwd.wr[i] && same_reg(fwd.addr[i], rb_addr)) begin
				rb_fwd = fwd.val[i];
			end
		end
		// instruction one ahead, still in execute
		if (fwd.exec_wr && same_reg(fwd.exec_addr, ra_addr)) begin
			ra_fwd = fwd.exec_val;
		end
		if (fwd.exec_wr && same_reg(fwd.exec_addr, rb_addr)) begin
			rb_fwd = fwd.exec_val;
		end
	end

	// control part of the rf/fwd register, reset to a nop
	always_ff @(posedge clk) begin
		if (reset) begin
			issue.op <= '0;
			issue.format <= fmt_rr;
			issue.reg_write <= 1'b0;
			issue.branch_taken <= 1'b0;
		end else begin
			issue.op <= op;
			issue.format <= format;
			issue.reg_write <= reg_write;
			issue.branch_taken <= branch_taken;
		end
	end

	// payload part
	always_ff @(posedge clk) begin
		issue.rt_addr <= rt_addr;
		issue.ra <= ra_fwd;
		issue.rb <= rb_fwd;
		issue.imm <= imm;
	end

endmodule

`default_nettype wire

// File: hw/permute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module permute_unit #(
	parameter int PERM_STAGES = spu_pkg::PERM_STAGES
) (
	input wire clk,
	input wire reset,
	odd_issue_if.exec issue,
	stage_fwd_if.source fwd,
	output spu_pkg::quad_t rt_wb,
	output spu_pkg::reg_addr_t rt_addr_wb,
	output logic reg_write_wb
);
	import spu_pkg::*;

	// decode results
	rot_mode_t rot_mode;
	shift_cnt_t rot_amount;
	logic sel_gather;
	logic kill_res;
	logic op_valid;
	quad_t gather_res;
	quad_t rot_res;

	// raw count from rb preferred word or i7
	shift_cnt_t cnt;
	// rotqmbyi uses the negated i7
	shift_cnt_t mask_cnt;

	logic squash;
	quad_t exec_val;
	reg_addr_t exec_addr;
	logic exec_wr;

	// delay line
	quad_t stage_val [PERM_STAGES];
	reg_addr_t stage_addr [PERM_STAGES];
	logic stage_wr [PERM_STAGES];

	assign cnt = (issue.format == fmt_rr) ? issue.rb[25:31] : issue.imm[11:17];
	assign mask_cnt = '0 - cnt;

	always_comb begin
		rot_mode = mode_rotl;
		rot_amount = '0;
		sel_gather = 1'b0;
		kill_res = 1'b0;
		op_valid = 1'b1;
		gather_res = '0;
		if (issue.format == fmt_rr || issue.format == fmt_ri7) begin
			case (issue.op)
				// bit counts modulo 8
				OP_SHLQBI, OP_SHLQBII: begin
					rot_mode = mode_shl;
					rot_amount = {4'b0000, cnt[2:0]};
				end
				OP_ROTQBI, OP_ROTQBII: begin
					rot_amount = {4'b0000, cnt[2:0]};
				end
				// byte counts of 16 and up clear everything
				OP_SHLQBY, OP_SHLQBYI: begin
					rot_mode = mode_shl;
					rot_amount = {cnt[3:0], 3'b000};
					kill_res = cnt[4];
				end
				OP_ROTQBY, OP_ROTQBYI: begin
					rot_amount = {cnt[3:0], 3'b000};
				end
				OP_ROTQMBYI: begin
					rot_mode = mode_shr;
					rot_amount = {mask_cnt[3:0], 3'b000};
					kill_res = mask_cnt[4];
				end
				// low bit of each byte into bits 16..31
				OP_GBB: begin
					sel_gather = 1'b1;
					for (int k = 0; k < 16; k++) begin
						gather_res[16 + k] = issue.ra[8 * k + 7];
					end
				end
				// halfwords into bits 24..31
				OP_GBH: begin
					sel_gather = 1'b1;
					for (int k = 0; k < 8; k++) begin
						gather_res[24 + k] = issue.ra[16 * k + 15];
					end
				end
				// words into bits 28..31
				OP_GB: begin
					sel_gather = 1'b1;
					for (int k = 0; k < 4; k++) begin
						gather_res[28 + k] = issue.ra[32 * k + 31];
					end
				end
				default: begin
					op_valid = 1'b0;
				end
			endcase
			// each opcode only counts in its own format
			if ((issue.format == fmt_ri7) != (issue.op inside {OP_SHLQBII, OP_SHLQBYI,
					OP_ROTQBII, OP_ROTQBYI, OP_ROTQMBYI})) begin
				op_valid = 1'b0;
			end
		end else begin
			op_valid = 1'b0;
		end
	end

	quad_rotator u_rot (
		.data(issue.ra),
		.amount(rot_amount),
		.mode(rot_mode),
		.result(rot_res)
	);

	// nop falls out as an invalid op
	assign squash = issue.branch_taken || !op_valid;
	assign exec_wr = issue.reg_write && !squash;
	// non-writing entries carry all zeros
	assign exec_addr = exec_wr ? issue.rt_addr : '0;
	always_comb begin
		if (!exec_wr) begin
			exec_val = '0;
		end else if (sel_gather) begin
			exec_val = gather_res;
		end else if (kill_res) begin
			exec_val = '0;
		end else begin
			exec_val = rot_res;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < PERM_STAGES; i++) begin
				stage_val[i] <= '0;
				stage_addr[i] <= '0;
				stage_wr[i] <= 1'b0;
			end
		end else begin
			stage_val[0] <= exec_val;
			stage_addr[0] <= exec_addr;
			stage_wr[0] <= exec_wr;
			for (int i = 1; i < PERM_STAGES; i++) begin
				stage_val[i] <= stage_val[i - 1];
				stage_addr[i] <= stage_addr[i - 1];
				stage_wr[i] <= stage_wr[i - 1];
			end
		end
	end

	// expose everything in flight for forwarding
	assign fwd.exec_val = exec_val;
	assign fwd.exec_addr = exec_addr;
	assign fwd.exec_wr = exec_wr;
	assign fwd.val = stage_val;
	assign fwd.addr = stage_addr;
	assign fwd.wr = stage_wr;

	// last stage is the writeback port
	assign rt_wb = stage_val[PERM_STAGES - 1];
	assign rt_addr_wb = stage_addr[PERM_STAGES - 1];
	assign reg_write_wb = stage_wr[PERM_STAGES - 1];

	assert property (@(posedge clk) disable iff (reset) !reg_write_wb |-> rt_wb == '0)
		else $error("writeback value nonzero while write flag low");

	// squashed work must never land in stage 0
	assert property (@(posedge clk) disable iff (reset) squash |=> !stage_wr[0])
		else $error("squashed instruction set stage 0 write flag");

endmodule

`default_nettype wire

// File: hw/quad_rotator.sv
`timescale 1ns/1ns
`default_nettype none

module quad_rotator (
	input wire spu_pkg::quad_t data,
	input wire spu_pkg::shift_cnt_t amount,
	input wire spu_pkg::rot_mode_t mode,
	output spu_pkg::quad_t result
);
	import spu_pkg::*;

	// largest byte shift the permute unit can request
	localparam int MAX_SHIFT = (QUAD_W / 8 - 1) * 8;

	quad_t rot_hi;
	quad_t rot_lo;

	// bit 0 is msb, so << moves bits toward bit 0
	assign rot_hi = data << amount;
	// wrapped part, zero for a count of 0
	assign rot_lo = data >> (QUAD_W - int'(amount));

	always_comb begin
		unique case (mode)
			mode_rotl: begin
				result = rot_hi | rot_lo;
			end
			mode_shl: begin
				// zero fill at bit 127 end
				result = rot_hi;
			end
			mode_shr: begin
				// toward bit 127, zero fill from bit 0
				result = data >> amount;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// overflowing byte shifts must be zeroed upstream, not passed here
	always_comb begin
		if (mode != mode_rotl) begin
			assert (amount <= MAX_SHIFT)
				else $error("shift count %0d beyond quadword byte range", amount);
		end
	end

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file #(
	parameter int NUM_REGS = 128
) (
	input wire clk,
	input wire reset,
	input wire spu_pkg::reg_addr_t ra_addr,
	input wire spu_pkg::reg_addr_t rb_addr,
	output spu_pkg::quad_t ra_data,
	output spu_pkg::quad_t rb_data,
	input wire wb_en,
	input wire spu_pkg::reg_addr_t wb_addr,
	input wire spu_pkg::quad_t wb_data,
	input wire load_en,
	input wire spu_pkg::reg_addr_t load_addr,
	input wire spu_pkg::quad_t load_data
);
	import spu_pkg::*;

	localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

	quad_t regs [NUM_REGS];

	// addresses wrap when fewer registers exist
	function automatic logic [IDX_W-1:0] fold(input reg_addr_t a);
		return IDX_W'(a % NUM_REGS);
	endfunction

	// async read, no write-through
	assign ra_data = regs[fold(ra_addr)];
	assign rb_data = regs[fold(rb_addr)];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (load_en) begin
				regs[fold(load_addr)] <= load_data;
			end
			// later assignment, so writeback beats a load to the same register
			if (wb_en) begin
				regs[fold(wb_addr)] <= wb_data;
			end
		end
	end

	// x on either write port would poison later reads
	assert property (@(posedge clk) disable iff (reset)
		!((wb_en && $isunknown(wb_data)) || (load_en && $isunknown(load_data))))
		else $error("unknown data written to register file");

endmodule

`default_nettype wire

// File: hw/spu_pkg.sv
`default_nettype none

package spu_pkg;

	// datapath and field widths
	localparam int QUAD_W = 128;
	localparam int ADDR_W = 7;
	localparam int OP_W = 11;
	localparam int IMM_W = 18;
	localparam int CNT_W = 7;

	// result delay line depth
	localparam int PERM_STAGES = 3;

	// isa fields keep bit 0 as msb
	typedef logic [0:QUAD_W-1] quad_t;
	typedef logic [0:ADDR_W-1] reg_addr_t;
	typedef logic [0:OP_W-1] opcode_t;
	typedef logic [0:IMM_W-1] imm_t;

	// plain count, lsb at index 0
	typedef logic [CNT_W-1:0] shift_cnt_t;

	// only rr and ri7 reach the permute unit
	typedef enum logic [2:0] {
		fmt_rr = 3'd0,
		fmt_rrr = 3'd1,
		fmt_ri7 = 3'd2,
		fmt_ri10 = 3'd3,
		fmt_ri16 = 3'd4,
		fmt_ri18 = 3'd5
	} instr_format_t;

	// rotator operation
	typedef enum logic [1:0] {
		mode_rotl = 2'd0,
		mode_shl = 2'd1,
		mode_shr = 2'd2
	} rot_mode_t;

	// rr format permute ops
	localparam opcode_t OP_SHLQBI = 11'b00111011011;
	localparam opcode_t OP_SHLQBY = 11'b00111011111;
	localparam opcode_t OP_ROTQBI = 11'b00111011000;
	localparam opcode_t OP_ROTQBY = 11'b00111011100;
	localparam opcode_t OP_GBB = 11'b00110110010;
	localparam opcode_t OP_GBH = 11'b00110110001;
	localparam opcode_t OP_GB = 11'b00110110000;

	// ri7 format permute ops
	localparam opcode_t OP_SHLQBII = 11'b00111111011;
	localparam opcode_t OP_SHLQBYI = 11'b00111111111;
	localparam opcode_t OP_ROTQBII = 11'b00111111000;
	localparam opcode_t OP_ROTQBYI = 11'b00111111100;
	localparam opcode_t OP_ROTQMBYI = 11'b00111111101;

endpackage

`default_nettype wire

// File: hw/stage_fwd_if.sv
`timescale 1ns/1ns
`default_nettype none

interface stage_fwd_if #(
	parameter int STAGES = spu_pkg::PERM_STAGES
);
	import spu_pkg::*;

	// result about to enter stage 0 at the next edge
	quad_t exec_val;
	reg_addr_t exec_addr;
	logic exec_wr;

	// delay line contents, index 0 youngest
	quad_t val [STAGES];
	reg_addr_t addr [STAGES];
	logic wr [STAGES];

	modport source (output exec_val, exec_addr, exec_wr, val, addr, wr);
	modport sink (input exec_val, exec_addr, exec_wr, val, addr, wr);

endinterface

`default_nettype wire

// File: testbench/tb_odd_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module tb_odd_pipe;
	import spu_pkg::*;

	// one expected writeback and the falling edge it is due at
	typedef struct packed {
		quad_t val;
		reg_addr_t addr;
		logic wr;
		logic [31:0] due;
	} wb_exp_t;

	logic clk = 1'b0;
	logic reset;
	opcode_t op;
	instr_format_t format;
	reg_addr_t rt_addr;
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	imm_t imm;
	logic reg_write;
	logic branch_taken;
	logic load_en;
	reg_addr_t load_addr;
	quad_t load_data;
	quad_t rt_wb;
	reg_addr_t rt_addr_wb;
	logic reg_write_wb;

	// reference state
	quad_t model_regs [128];
	wb_exp_t exp_q [$];
	wb_exp_t head;
	logic [31:0] rng_state = 32'he09783ff;
	logic [31:0] neg_count = 0;
	int errors = 0;
	int checks = 0;
	int timeouts = 0;

	odd_pipe_top dut0 (
		.clk(clk), .reset(reset), .op(op), .format(format), .rt_addr(rt_addr),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .imm(imm), .reg_write(reg_write),
		.branch_taken(branch_taken), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .rt_wb(rt_wb), .rt_addr_wb(rt_addr_wb),
		.reg_write_wb(reg_write_wb)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic quad_t rand_quad();
		return {next_rand(), next_rand(), next_rand(), next_rand()};
	endfunction

	function automatic opcode_t rr_op(input int k);
		case (k)
			0: return OP_SHLQBI;
			1: return OP_SHLQBY;
			2: return OP_ROTQBI;
			3: return OP_ROTQBY;
			4: return OP_GBB;
			5: return OP_GBH;
			default: return OP_GB;
		endcase
	endfunction

	function automatic opcode_t ri7_op(input int k);
		case (k)
			0: return OP_SHLQBII;
			1: return OP_SHLQBYI;
			2: return OP_ROTQBII;
			3: return OP_ROTQBYI;
			default: return OP_ROTQMBYI;
		endcase
	endfunction

	// bit 0 is the left end
	function automatic quad_t move_bits(input quad_t d, input int n, input rot_mode_t m);
		quad_t r;
		for (int i = 0; i < 128; i++) begin
			if (m == mode_rotl) begin
				r[i] = d[(i + n) % 128];
			end else if (m == mode_shl) begin
				r[i] = (i + n < 128) ? d[i + n] : 1'b0;
			end else begin
				r[i] = (i - n >= 0) ? d[i - n] : 1'b0;
			end
		end
		return r;
	endfunction

	// lsb of each element into the low end of the preferred word
	function automatic quad_t gather_bits(input quad_t d, input int width);
		quad_t r;
		int n;
		r = '0;
		n = 128 / width;
		for (int k = 0; k < n; k++) begin
			r[32 - n + k] = d[width * k + width - 1];
		end
		return r;
	endfunction

	function automatic quad_t model_result(input opcode_t o, input instr_format_t f,
			input quad_t a, input quad_t b, input imm_t im, output logic valid);
		int cnt;
		quad_t r;
		r = '0;
		valid = 1'b1;
		// preferred word of rb or the i7 field
		cnt = (f == fmt_rr) ? int'(b[0:31] % 128) : int'(im[11:17]);
		if (f == fmt_rr && (o == OP_SHLQBI)) r = move_bits(a, cnt % 8, mode_shl);
		else if (f == fmt_rr && (o == OP_ROTQBI)) r = move_bits(a, cnt % 8, mode_rotl);
		else if (f == fmt_rr && (o == OP_SHLQBY))
			r = (cnt % 32 >= 16) ? '0 : move_bits(a, (cnt % 32) * 8, mode_shl);
		else if (f == fmt_rr && (o == OP_ROTQBY)) r = move_bits(a, (cnt % 16) * 8, mode_rotl);
		else if (f == fmt_rr && (o == OP_GBB)) r = gather_bits(a, 8);
		else if (f == fmt_rr && (o == OP_GBH)) r = gather_bits(a, 16);
		else if (f == fmt_rr && (o == OP_GB)) r = gather_bits(a, 32);
		else if (f == fmt_ri7 && (o == OP_SHLQBII)) r = move_bits(a, cnt % 8, mode_shl);
		else if (f == fmt_ri7 && (o == OP_ROTQBII)) r = move_bits(a, cnt % 8, mode_rotl);
		else if (f == fmt_ri7 && (o == OP_SHLQBYI))
			r = (cnt % 32 >= 16) ? '0 : move_bits(a, (cnt % 32) * 8, mode_shl);
		else if (f == fmt_ri7 && (o == OP_ROTQBYI)) r = move_bits(a, (cnt % 16) * 8, mode_rotl);
		else if (f == fmt_ri7 && (o == OP_ROTQMBYI))
			// negated count modulo 32
			r = ((32 - cnt % 32) % 32 >= 16) ? '0 :
				move_bits(a, ((32 - cnt % 32) % 32) * 8, mode_shr);
		else valid = 1'b0;
		return r;
	endfunction

	// drive one instruction and queue its writeback five falling edges out
	task automatic issue_instr(input opcode_t o, input instr_format_t f, input reg_addr_t rt,
			input reg_addr_t ra, input reg_addr_t rb, input imm_t im, input logic wr,
			input logic br);
		quad_t res;
		logic valid;
		wb_exp_t e;
		@(posedge clk);
		op <= o;
		format <= f;
		rt_addr <= rt;
		ra_addr <= ra;
		rb_addr <= rb;
		imm <= im;
		reg_write <= wr;
		branch_taken <= br;
		load_en <= 1'b0;
		res = model_result(o, f, model_regs[ra], model_regs[rb], im, valid);
		e.wr = wr && !br && valid;
		e.val = e.wr ? res : '0;
		e.addr = e.wr ? rt : '0;
		e.due = neg_count + 5;
		exp_q.push_back(e);
		// forwarding makes the pipe look sequential
		if (e.wr) model_regs[rt] = res;
	endtask

	// load rides along with a nop
	task automatic load_reg(input reg_addr_t a, input quad_t d);
		issue_instr('0, fmt_rr, '0, '0, '0, '0, 1'b0, 1'b0);
		load_en <= 1'b1;
		load_addr <= a;
		load_data <= d;
		model_regs[a] = d;
	endtask

	// rotate by zero bytes copies a register onto itself
	task automatic readback_all();
		for (int r = 0; r < 128; r++) begin
			issue_instr(OP_ROTQBYI, fmt_ri7, reg_addr_t'(r), reg_addr_t'(r), reg_addr_t'(r),
				'0, 1'b1, 1'b0);
		end
	endtask

	task automatic issue_random(input logic ri7, input reg_addr_t ra, input reg_addr_t rb,
			output reg_addr_t rt);
		rt = reg_addr_t'(next_rand());
		if (ri7) issue_instr(ri7_op(int'(next_rand() % 5)), fmt_ri7, rt, ra, rb,
			imm_t'(next_rand()), 1'b1, 1'b0);
		else issue_instr(rr_op(int'(next_rand() % 7)), fmt_rr, rt, ra, rb,
			imm_t'(next_rand()), 1'b1, 1'b0);
	endtask

	task automatic drain(output logic ok);
		int waited;
		waited = 0;
		issue_instr('0, fmt_rr, '0, '0, '0, '0, 1'b0, 1'b0);
		while (exp_q.size() > 0 && waited < 32) begin
			@(negedge clk);
			waited++;
		end
		ok = (exp_q.size() == 0);
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		neg_count = neg_count + 1;
		if (exp_q.size() > 0 && exp_q[0].due == neg_count) begin
			head = exp_q.pop_front();
			checks++;
			assert (rt_wb === head.val && rt_addr_wb === head.addr && reg_write_wb === head.wr)
				else begin
					errors++;
					$display("ERROR %0t: wb %h addr %0d wr %b, expected %h addr %0d wr %b",
						$time, rt_wb, rt_addr_wb, reg_write_wb, head.val, head.addr, head.wr);
				end
		end
	end

	initial begin
		reg_addr_t rt;
		reg_addr_t recent [3];
		int sel;
		int bad_fmt;
		logic ok;
		reset = 1'b1;
		// a writing op held during reset must not leak into the delay line
		op = OP_ROTQBYI;
		format = fmt_ri7;
		rt_addr = '0;
		ra_addr = '0;
		rb_addr = '0;
		imm = '0;
		reg_write = 1'b1;
		branch_taken = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (int r = 0; r < 128; r++) model_regs[r] = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		op <= '0;
		format <= fmt_rr;
		reg_write <= 1'b0;
		// delay line starts empty
		for (int c = 0; c < 3; c++) begin
			@(negedge clk);
			checks++;
			assert (reg_write_wb === 1'b0)
				else begin
					errors++;
					$display("ERROR %0t: write flag high right after reset", $time);
				end
		end
		for (int r = 0; r < 128; r++) load_reg(reg_addr_t'(r), rand_quad());
		readback_all();
		// register-register forms then immediate forms
		for (int n = 0; n < 200; n++)
			issue_random(1'b0, reg_addr_t'(next_rand()), reg_addr_t'(next_rand()), rt);
		for (int n = 0; n < 200; n++)
			issue_random(1'b1, reg_addr_t'(next_rand()), reg_addr_t'(next_rand()), rt);
		// sources taken from the last three destinations
		for (int n = 0; n < 3; n++)
			issue_random(1'b0, reg_addr_t'(next_rand()), reg_addr_t'(next_rand()), recent[n]);
		for (int n = 0; n < 200; n++) begin
			issue_random(next_rand() % 2 == 1, recent[next_rand() % 3],
				recent[next_rand() % 3], rt);
			recent[2] = recent[1];
			recent[1] = recent[0];
			recent[0] = rt;
		end
		// squashed and undefined work mixed with real work
		for (int n = 0; n < 150; n++) begin
			sel = int'(next_rand() % 7);
			rt = reg_addr_t'(next_rand());
			bad_fmt = int'(next_rand() % 6);
			bad_fmt = (bad_fmt == 0) ? 1 : bad_fmt + 2;
			case (sel)
				0: issue_instr(rr_op(int'(next_rand() % 7)), fmt_rr, rt,
					reg_addr_t'(next_rand()), reg_addr_t'(next_rand()), '0, 1'b1, 1'b1);
				1: issue_instr('0, fmt_rr, rt, '0, '0, '0, 1'b1, 1'b0);
				2: issue_instr(opcode_t'(next_rand()), fmt_rr, rt,
					reg_addr_t'(next_rand()), reg_addr_t'(next_rand()), '0, 1'b1, 1'b0);
				3: issue_instr(ri7_op(int'(next_rand() % 5)), instr_format_t'(3'(bad_fmt)),
					rt, reg_addr_t'(next_rand()), '0, imm_t'(next_rand()), 1'b1, 1'b0);
				// opcodes swapped across the two formats
				4: issue_instr(rr_op(int'(next_rand() % 7)), fmt_ri7, rt,
					reg_addr_t'(next_rand()), reg_addr_t'(next_rand()),
					imm_t'(next_rand()), 1'b1, 1'b0);
				5: issue_instr(ri7_op(int'(next_rand() % 5)), fmt_rr, rt,
					reg_addr_t'(next_rand()), reg_addr_t'(next_rand()),
					imm_t'(next_rand()), 1'b1, 1'b0);
				default: issue_random(1'b0, reg_addr_t'(next_rand()),
					reg_addr_t'(next_rand()), rt);
			endcase
		end
		readback_all();
		drain(ok);
		if (!ok) begin
			timeouts++;
			$display("timed out waiting for queued writebacks to appear");
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
